// File: sa_params.svh
`ifndef SA_PARAMS_SVH
`define SA_PARAMS_SVH

// array geometry
`define SA_DIM 5
`define SA_DATA_W 32
`define SA_IDX_W 3

// operand queue depth doubles as the upstream credit count
`define SA_IN_DEPTH 8
`define SA_OUT_DEPTH 8

`define SA_IN_CNT_W ($clog2(`SA_IN_DEPTH + 1))
`define SA_OUT_CNT_W ($clog2(`SA_OUT_DEPTH + 1))

// last product reaches the far corner 2*(dim-1) cycles after the last beat
`define SA_FLUSH_CYCLES (2 * (`SA_DIM - 1))

// first pop to last result push
`define SA_JOB_CYCLES (`SA_DIM + `SA_FLUSH_CYCLES + `SA_DIM)

`endif

// File: sa_pkg.sv
`include "sa_params.svh"

package sa_pkg;

    typedef logic [`SA_DATA_W-1:0] elem_t;

    // lane i sits at index i
    typedef elem_t [`SA_DIM-1:0] vec_t;

    // beat k carries column k of A and row k of B
    typedef struct packed {
        vec_t a_col;
        vec_t b_row;
    } operand_beat_t;

    typedef struct packed {
        logic [`SA_IDX_W-1:0] row_idx;
        vec_t                 row;
    } result_beat_t;

    typedef enum logic [1:0] {
        PE_CLEAR = 2'd0,
        PE_MAC   = 2'd1,
        PE_DRAIN = 2'd2
    } pe_mode_t;

endpackage

// File: credit_fifo.sv
`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic [$clog2(DEPTH + 1)-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // show-ahead head of queue
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer spent a credit it did not hold
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != FULL))
        else $error("credit_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count != '0))
        else $error("credit_fifo: pop while empty");

endmodule

// File: skew_feeder.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module skew_feeder
    import sa_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          feed_valid,
    input  operand_beat_t beat,
    output vec_t          west,
    output vec_t          north
);

    vec_t a_lanes;
    vec_t b_lanes;

    // zeros between jobs keep the flush from adding to the sums
    assign a_lanes = feed_valid ? beat.a_col : '0;
    assign b_lanes = feed_valid ? beat.b_row : '0;

    assign west[0]  = a_lanes[0];
    assign north[0] = b_lanes[0];

    for (genvar i = 1; i < `SA_DIM; i++) begin : g_lane
        // lane i needs i stages
        elem_t a_sr [i];
        elem_t b_sr [i];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int j = 0; j < i; j++) begin
                    a_sr[j] <= '0;
                    b_sr[j] <= '0;
                end
            end else begin
                a_sr[0] <= a_lanes[i];
                b_sr[0] <= b_lanes[i];
                for (int j = 1; j < i; j++) begin
                    a_sr[j] <= a_sr[j-1];
                    b_sr[j] <= b_sr[j-1];
                end
            end
        end

        assign west[i]  = a_sr[i-1];
        assign north[i] = b_sr[i-1];
    end

endmodule

// File: mac_pe.sv
`timescale 1ns/10ps

module mac_pe
    import sa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pe_mode_t mode,
    input  elem_t    a_in,
    input  elem_t    b_in,
    input  elem_t    acc_in,
    output elem_t    a_out,
    output elem_t    b_out,
    output elem_t    acc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else begin
            case (mode)
                PE_MAC: begin
                    // product and sum both wrap at 32 bits
                    acc   <= acc + a_in * b_in;
                    a_out <= a_in;
                    b_out <= b_in;
                end
                PE_DRAIN: begin
                    // take the accumulator of the element above
                    acc   <= acc_in;
                    a_out <= a_in;
                    b_out <= b_in;
                end
                default: begin
                    acc   <= '0;
                    a_out <= '0;
                    b_out <= '0;
                end
            endcase
        end
    end

endmodule

// File: pe_array.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module pe_array
    import sa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pe_mode_t mode,
    input  vec_t     west,
    input  vec_t     north,
    output vec_t     south_acc
);

    // indexed [row][col]
    elem_t a_in_w   [`SA_DIM][`SA_DIM];
    elem_t b_in_w   [`SA_DIM][`SA_DIM];
    elem_t acc_in_w [`SA_DIM][`SA_DIM];
    elem_t a_out_w  [`SA_DIM][`SA_DIM];
    elem_t b_out_w  [`SA_DIM][`SA_DIM];
    elem_t acc_w    [`SA_DIM][`SA_DIM];

    for (genvar r = 0; r < `SA_DIM; r++) begin : g_row
        for (genvar c = 0; c < `SA_DIM; c++) begin : g_col
            if (c == 0) begin : g_edge_w
                assign a_in_w[r][c] = west[r];
            end else begin : g_inner_w
                assign a_in_w[r][c] = a_out_w[r][c-1];
            end

            // top row drains in zeros
            if (r == 0) begin : g_edge_n
                assign b_in_w[r][c]   = north[c];
                assign acc_in_w[r][c] = '0;
            end else begin : g_inner_n
                assign b_in_w[r][c]   = b_out_w[r-1][c];
                assign acc_in_w[r][c] = acc_w[r-1][c];
            end

            mac_pe pe_i (
                .clk    (clk),
                .rst    (rst),
                .mode   (mode),
                .a_in   (a_in_w[r][c]),
                .b_in   (b_in_w[r][c]),
                .acc_in (acc_in_w[r][c]),
                .a_out  (a_out_w[r][c]),
                .b_out  (b_out_w[r][c]),
                .acc    (acc_w[r][c])
            );
        end
    end

    for (genvar c = 0; c < `SA_DIM; c++) begin : g_south
        assign south_acc[c] = acc_w[`SA_DIM-1][c];
    end

endmodule

// File: array_sequencer.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module array_sequencer
    import sa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`SA_IN_CNT_W-1:0]   in_count,
    input  logic [`SA_OUT_CNT_W-1:0]  out_free,
    output logic                      pop,
    output logic                      feed_valid,
    output pe_mode_t                  mode,
    input  vec_t                      south_acc,
    output logic                      res_push,
    output result_beat_t              res_beat
);

    localparam int IN_W  = `SA_IN_CNT_W;
    localparam int OUT_W = `SA_OUT_CNT_W;
    localparam int PH_W  = $clog2(`SA_FLUSH_CYCLES + `SA_DIM);
    localparam logic [IN_W-1:0]  MIN_IN     = IN_W'(`SA_DIM);
    localparam logic [OUT_W-1:0] MIN_OUT    = OUT_W'(`SA_DIM);
    localparam logic [PH_W-1:0]  DIM_LAST   = PH_W'(`SA_DIM - 1);
    localparam logic [PH_W-1:0]  FLUSH_LAST = PH_W'(`SA_FLUSH_CYCLES - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_FLUSH,
        S_DRAIN
    } state_t;

    state_t          state;
    logic [PH_W-1:0] phase;
    logic            phase_last;
    logic            can_start;
    logic [PH_W-1:0] drain_row;

    // the push of this cycle is not yet counted in out_free
    assign can_start = (in_count >= MIN_IN) && (out_free >= MIN_OUT + OUT_W'(res_push));

    always_comb begin
        case (state)
            S_LOAD:  phase_last = (phase == DIM_LAST);
            S_FLUSH: phase_last = (phase == FLUSH_LAST);
            S_DRAIN: phase_last = (phase == DIM_LAST);
            default: phase_last = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            phase <= '0;
        end else begin
            if (state == S_IDLE || phase_last) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            case (state)
                S_IDLE:  if (can_start) state <= S_LOAD;
                S_LOAD:  if (phase_last) state <= S_FLUSH;
                S_FLUSH: if (phase_last) state <= S_DRAIN;
                // drain leaves every accumulator at zero, so a new job may follow
                S_DRAIN: if (phase_last) state <= can_start ? S_LOAD : S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign pop        = (state == S_LOAD);
    assign feed_valid = (state == S_LOAD);
    assign res_push   = (state == S_DRAIN);

    always_comb begin
        case (state)
            S_LOAD, S_FLUSH: mode = PE_MAC;
            S_DRAIN:         mode = PE_DRAIN;
            default:         mode = PE_CLEAR;
        endcase
    end

    // bottom row leaves first
    assign drain_row = DIM_LAST - phase;

    always_comb begin
        res_beat.row_idx = drain_row[`SA_IDX_W-1:0];
        res_beat.row     = south_acc;
    end

    // start check must keep the operand queue ahead of the load
    a_pop_in_load: assert property (@(posedge clk) disable iff (rst)
        pop |-> (in_count > IN_W'(DIM_LAST - phase)))
        else $error("array_sequencer: operand queue short of the beats left in the load");

    // start check reserves a slot for every row still to drain
    a_push_in_drain: assert property (@(posedge clk) disable iff (rst)
        res_push |-> (out_free > OUT_W'(DIM_LAST - phase)))
        else $error("array_sequencer: result queue short of the rows left in the drain");

endmodule

// File: result_sender.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module result_sender
    import sa_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     res_push,
    input  result_beat_t             res_beat,
    output logic [`SA_OUT_CNT_W-1:0] out_free,
    input  logic                     out_credit,
    output logic                     out_valid,
    output result_beat_t             out_beat
);

    localparam int OUT_W = `SA_OUT_CNT_W;
    localparam logic [OUT_W-1:0] Q_DEPTH = OUT_W'(`SA_OUT_DEPTH);

    logic [OUT_W-1:0] q_count;
    logic [OUT_W-1:0] credits;

    credit_fifo #(
        .payload_t (result_beat_t),
        .DEPTH     (`SA_OUT_DEPTH)
    ) res_q_i (
        .clk       (clk),
        .rst       (rst),
        .push      (res_push),
        .push_data (res_beat),
        .pop       (out_valid),
        .pop_data  (out_beat),
        .count     (q_count)
    );

    // one beat per held credit
    assign out_valid = (credits != '0) && (q_count != '0);
    assign out_free  = Q_DEPTH - q_count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= '0;
        end else begin
            case ({out_credit, out_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // downstream has no more slots than this
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= Q_DEPTH)
        else $error("result_sender: downstream returned too many credits");

endmodule

// File: matmul_top.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module matmul_top
    import sa_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  operand_beat_t in_beat,
    output logic          in_credit,
    output logic          out_valid,
    output result_beat_t  out_beat,
    input  logic          out_credit
);

    logic [`SA_IN_CNT_W-1:0]  in_count;
    logic [`SA_OUT_CNT_W-1:0] out_free;
    operand_beat_t            head_beat;
    logic                     feed_valid;
    pe_mode_t                 mode;
    vec_t                     west;
    vec_t                     north;
    vec_t                     south_acc;
    logic                     res_push;
    result_beat_t             res_beat;

    // every pop hands one credit back upstream
    credit_fifo #(
        .payload_t (operand_beat_t),
        .DEPTH     (`SA_IN_DEPTH)
    ) op_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid),
        .push_data (in_beat),
        .pop       (in_credit),
        .pop_data  (head_beat),
        .count     (in_count)
    );

    array_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .in_count   (in_count),
        .out_free   (out_free),
        .pop        (in_credit),
        .feed_valid (feed_valid),
        .mode       (mode),
        .south_acc  (south_acc),
        .res_push   (res_push),
        .res_beat   (res_beat)
    );

    skew_feeder feeder_i (
        .clk        (clk),
        .rst        (rst),
        .feed_valid (feed_valid),
        .beat       (head_beat),
        .west       (west),
        .north      (north)
    );

    pe_array array_i (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .west      (west),
        .north     (north),
        .south_acc (south_acc)
    );

    result_sender sender_i (
        .clk        (clk),
        .rst        (rst),
        .res_push   (res_push),
        .res_beat   (res_beat),
        .out_free   (out_free),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

endmodule

// File: tb_matmul.sv
`timescale 1ns/10ps
`include "sa_params.svh"

module tb_matmul
    import sa_pkg::*;
();

    localparam int NJOBS       = 12;
    localparam int DIM         = `SA_DIM;
    localparam int IDX_W       = `SA_IDX_W;
    localparam int TOTAL_BEATS = NJOBS * DIM;
    localparam int TOTAL_ROWS  = NJOBS * DIM;
    localparam int LIMIT       = (NJOBS * `SA_JOB_CYCLES + 16) * 4 + 200;

    logic          clk;
    logic          rst;
    logic          in_valid;
    operand_beat_t in_beat;
    logic          in_credit;
    logic          out_valid;
    result_beat_t  out_beat;
    logic          out_credit;

    // job table of operands, expected products and credit patterns
    elem_t  a_m   [NJOBS][DIM][DIM];
    elem_t  b_m   [NJOBS][DIM][DIM];
    elem_t  exp_c [NJOBS][DIM][DIM];
    logic   gaps  [NJOBS];
    string  names [NJOBS];

    integer seed;
    int     cycles;
    int     errors;
    int     err_base;
    int     tests_failed;
    int     beats_sent;
    int     credit_pulses;
    int     in_credits;
    int     rx_rows;
    int     granted;
    int     valid_cycles;
    int     free_slots;

    matmul_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // C[r][c] is the sum over k of A[r][k] * B[k][c] mod 2^32
    function automatic elem_t ref_element(input int j, input int r, input int c);
        elem_t s;
        s = '0;
        for (int k = 0; k < DIM; k++) begin
            s = s + a_m[j][r][k] * b_m[j][k][c];
        end
        return s;
    endfunction

    task automatic build_table();
        for (int j = 0; j < NJOBS; j++) begin
            gaps[j] = (j >= 10);
            case (j)
                0:       names[j] = "identity x B";
                1:       names[j] = "small integers";
                2:       names[j] = "wrap near 2^32";
                3:       names[j] = "zero after nonzero";
                10, 11:  names[j] = "random, credit gaps";
                default: names[j] = "random, back to back";
            endcase
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    case (j)
                        0: begin
                            a_m[j][r][c] = (r == c) ? 32'd1 : 32'd0;
                            b_m[j][r][c] = r * 5 + c + 1;
                        end
                        1: begin
                            a_m[j][r][c] = r * 7 + c * 3 + 1;
                            b_m[j][r][c] = 10 * r + c + 2;
                        end
                        2: begin
                            a_m[j][r][c] = 32'hFFFF_FFFF - r - c;
                            b_m[j][r][c] = 32'hFFFF_FFF0 + r * 5 + c;
                        end
                        3: begin
                            a_m[j][r][c] = '0;
                            b_m[j][r][c] = '0;
                        end
                        default: begin
                            a_m[j][r][c] = $random(seed);
                            b_m[j][r][c] = $random(seed);
                        end
                    endcase
                end
            end
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    exp_c[j][r][c] = ref_element(j, r, c);
                end
            end
        end
    endtask

    // beat k carries column k of A and row k of B
    function automatic operand_beat_t make_beat(input int j, input int k);
        operand_beat_t b;
        for (int i = 0; i < DIM; i++) begin
            b.a_col[i] = a_m[j][i][k];
            b.b_row[i] = b_m[j][k][i];
        end
        return b;
    endfunction

    task automatic report_job(input int jb);
        if (errors == err_base) begin
            $display("job %0d (%s): ok", jb, names[jb]);
        end else begin
            $display("job %0d (%s): %0d errors", jb, names[jb], errors - err_base);
            tests_failed++;
        end
        err_base = errors;
    endtask

    always @(posedge clk) begin
        cycles++;
    end

    // upstream spends one credit per beat
    always @(posedge clk) begin : in_side
        if (rst) begin
            in_valid   <= 1'b0;
            in_credits = `SA_IN_DEPTH;
        end else begin
            if (in_credit) begin
                credit_pulses++;
                in_credits++;
            end
            assert (credit_pulses <= beats_sent) else begin
                $display("CHECK FAILED t=%0t %0d in_credit pulses for %0d beats sent",
                         $time, credit_pulses, beats_sent);
                errors++;
            end
            if (beats_sent < TOTAL_BEATS && in_credits > 0) begin
                in_valid <= 1'b1;
                in_beat  <= make_beat(beats_sent / DIM, beats_sent % DIM);
                in_credits--;
                beats_sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    // downstream frees a slot as soon as a beat lands
    always @(posedge clk) begin : out_side
        int           jb;
        int           r;
        result_beat_t exp_beat;
        if (rst) begin
            out_credit <= 1'b0;
        end else begin
            if (out_credit) begin
                granted++;
            end
            if (out_valid) begin
                valid_cycles++;
                free_slots++;
                assert (rx_rows < TOTAL_ROWS) else begin
                    $display("unexpected extra result beat at %0t", $time);
                    errors++;
                end
                if (rx_rows < TOTAL_ROWS) begin
                    jb = rx_rows / DIM;
                    r  = DIM - 1 - rx_rows % DIM;
                    exp_beat.row_idx = IDX_W'(r);
                    for (int c = 0; c < DIM; c++) begin
                        exp_beat.row[c] = exp_c[jb][r][c];
                    end
                    assert (out_beat == exp_beat) else begin
                        $display("CHECK FAILED t=%0t job %0d row %0d: got idx %0d row %h",
                                 $time, jb, r, out_beat.row_idx, out_beat.row);
                        $display("    expected idx %0d row %h", exp_beat.row_idx, exp_beat.row);
                        errors++;
                    end
                    rx_rows++;
                    if (r == 0) begin
                        report_job(jb);
                    end
                end
            end
            assert (valid_cycles <= granted) else begin
                $display("CHECK FAILED t=%0t %0d out_valid cycles for %0d credits",
                         $time, valid_cycles, granted);
                errors++;
            end
            jb = (rx_rows / DIM < NJOBS) ? rx_rows / DIM : NJOBS - 1;
            if (free_slots > 0 && (!gaps[jb] || ($random(seed) & 3) == 0)) begin
                out_credit <= 1'b1;
                free_slots--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        seed          = 32'h63292bb8;
        cycles        = 0;
        errors        = 0;
        err_base      = 0;
        tests_failed  = 0;
        beats_sent    = 0;
        credit_pulses = 0;
        in_credits    = `SA_IN_DEPTH;
        rx_rows       = 0;
        granted       = 0;
        valid_cycles  = 0;
        free_slots    = `SA_OUT_DEPTH;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_credit    = 1'b0;
        build_table();

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        while (rx_rows < TOTAL_ROWS && cycles < LIMIT) begin
            @(negedge clk);
        end
        // let any duplicate beat show up
        repeat (20) @(negedge clk);

        if (rx_rows < TOTAL_ROWS) begin
            $display("timeout: %0d of %0d result rows arrived within %0d cycles",
                     rx_rows, TOTAL_ROWS, LIMIT);
            errors++;
        end
        assert (credit_pulses == beats_sent) else begin
            $display("CHECK FAILED t=%0t %0d in_credit pulses for %0d beats sent",
                     $time, credit_pulses, beats_sent);
            errors++;
        end

        $display("%0d jobs, %0d failed, %0d errors, %0d rows received",
                 NJOBS, tests_failed, errors, rx_rows);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
sa_pkg.sv
credit_fifo.sv
skew_feeder.sv
mac_pe.sv
pe_array.sv
array_sequencer.sv
result_sender.sv
matmul_top.sv
tb_matmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_matmul -f files.f -o Vtb_matmul

./obj_dir/Vtb_matmul | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
